//--- hw/boothPkg.sv
/*
 * Booth arithmetic definitions
 *   boothDigitT  radix-4 digit as sign plus one-hot magnitude
 *   digitCount   digits needed for an operand width
 *   levelRows, treeLevels  sizing of the 4-to-2 reduction tree
 */
package boothPkg;

    // zero is all bits clear, never negative
    typedef struct packed {
        logic neg;
        logic two;
        logic one;
    } boothDigitT;

    // opWidth/2 digits plus one for the zero-extended unsigned operand
    function automatic int digitCount(int opWidth);
        return opWidth / 2 + 1;
    endfunction

    // rows entering a level; each group of four becomes two,
    // a leftover of three gets its own reducer with a zero fourth row
    function automatic int levelRows(int rowCount, int level);
        int rows;
        rows = rowCount;
        for (int lvl = 0; lvl < level; lvl++) begin
            if (rows % 4 == 3) begin
                rows = (rows / 4) * 2 + 2;
            end else begin
                rows = (rows / 4) * 2 + rows % 4;
            end
        end
        return rows;
    endfunction

    // levels until only the sum and carry rows remain
    function automatic int treeLevels(int rowCount);
        int levels;
        levels = 0;
        while (levelRows(rowCount, levels) > 2) begin
            levels++;
        end
        return levels;
    endfunction

endpackage

//--- hw/mulPipePkg.sv
/*
 * Multiplier pipeline control
 *   tagWidth  width of the request tag
 *   mulCtlT   valid, operand mode and tag travelling with the data
 */
package mulPipePkg;

    parameter int tagWidth = 8;

    // rides beside the operands through every register stage
    typedef struct packed {
        logic                valid;
        // 1 for two's complement operands, 0 for unsigned
        logic                signedMode;
        logic [tagWidth-1:0] tag;
    } mulCtlT;

endpackage

//--- hw/boothEncoder.sv
/*
 * boothEncoder
 *   radix-4 recoding of the multiplier into boothPkg digits
 *   signed or unsigned operand selected per request
 */
`timescale 1ns/10ps

module boothEncoder #(
    parameter int opWidth = 32
) (
    input  logic [opWidth-1:0]  multiplier,
    input  logic                signedMode,
    output boothPkg::boothDigitT digits [boothPkg::digitCount(opWidth)]
);
    import boothPkg::*;

    localparam int numDigits = digitCount(opWidth);

    // sign bit in signed mode, zero otherwise
    logic                extBit;
    // two extension bits on top, implicit zero below bit 0
    logic [opWidth+2:0]  extMult;

    assign extBit  = signedMode & multiplier[opWidth-1];
    assign extMult = {extBit, extBit, multiplier, 1'b0};

    // digit k looks at multiplier bits 2k+1, 2k, 2k-1
    // the top window is 000 or 111 in signed mode so that digit is zero there
    // in unsigned mode it picks up the msb as +1
    for (genvar k = 0; k < numDigits; k++) begin : genDigit
        logic [2:0] win;

        assign win = extMult[2*k+2 -: 3];

        // 100 101 110 are negative, 111 is a positive zero
        // magnitude one for 001 010 101 110
        // magnitude two only for 011 and 100
        assign digits[k] = '{
            neg: win[2] & ~(win[1] & win[0]),
            two: (win[2] & ~win[1] & ~win[0]) | (~win[2] & win[1] & win[0]),
            one: win[1] ^ win[0]
        };
    end

endmodule

//--- hw/partialProductGen.sv
/*
 * partialProductGen
 *   one partial-product row per Booth digit
 *   rows are sign-extended to full product width and pre-shifted
 */
`timescale 1ns/10ps

module partialProductGen #(
    parameter int opWidth = 32
) (
    input  logic [opWidth-1:0]   multiplicand,
    input  logic                 signedMode,
    input  boothPkg::boothDigitT digits [boothPkg::digitCount(opWidth)],
    output logic [2*opWidth-1:0] rows   [boothPkg::digitCount(opWidth)]
);
    import boothPkg::*;

    localparam int numDigits = digitCount(opWidth);
    localparam int rowWidth  = 2 * opWidth;
    // room for 2A of an opWidth+1 bit signed value
    localparam int ppWidth   = opWidth + 2;

    // multiplicand as an opWidth+1 bit signed number in both modes
    logic [opWidth:0]   extA;
    logic [opWidth:0]   negA;
    logic [ppWidth-1:0] posOne;
    logic [ppWidth-1:0] posTwo;
    logic [ppWidth-1:0] negOne;
    logic [ppWidth-1:0] negTwo;

    assign extA = {signedMode & multiplicand[opWidth-1], multiplicand};

    // formed once and shared by every row
    // the extra bit keeps -(most negative) and -(unsigned max) exact
    assign negA = ~extA + 1'b1;

    assign posOne = {extA[opWidth], extA};
    assign posTwo = {extA, 1'b0};
    assign negOne = {negA[opWidth], negA};
    assign negTwo = {negA, 1'b0};

    for (genvar k = 0; k < numDigits; k++) begin : genRow
        logic [ppWidth-1:0]  ppVal;
        logic [rowWidth-1:0] ppFull;

        // zero digit gives an all-zero row whatever neg says
        always_comb begin
            if (digits[k].two) begin
                ppVal = digits[k].neg ? negTwo : posTwo;
            end else if (digits[k].one) begin
                ppVal = digits[k].neg ? negOne : posOne;
            end else begin
                ppVal = '0;
            end
        end

        // sign bits all the way to the product msb
        // bits past the msb after the shift drop out, the sum is modulo 2^rowWidth anyway
        assign ppFull  = {{(rowWidth - ppWidth){ppVal[ppWidth-1]}}, ppVal};
        // digit k carries weight 4^k
        assign rows[k] = ppFull << (2 * k);
    end

endmodule

//--- hw/reducer4to2.sv
/*
 * reducer4to2
 *   row of 4-to-2 compressor cells
 *   sum row plus a carry row already shifted one place left
 */
`timescale 1ns/10ps

module reducer4to2 #(
    parameter int rowWidth = 64
) (
    input  logic [rowWidth-1:0] w,
    input  logic [rowWidth-1:0] x,
    input  logic [rowWidth-1:0] y,
    input  logic [rowWidth-1:0] z,
    output logic [rowWidth-1:0] sum,
    output logic [rowWidth-1:0] carry
);

    // chain carry into each cell, same weight as that cell's sum bit
    logic [rowWidth-1:0] chainIn;

    assign chainIn[0] = 1'b0;
    assign carry[0]   = 1'b0;

    // each cell counts five inputs: w, x, y, z and chainIn
    // result = sum + 2 * (carry + chain-out)
    for (genvar i = 0; i < rowWidth; i++) begin : genCell
        logic quadParity;

        assign quadParity = w[i] ^ x[i] ^ y[i] ^ z[i];

        // five-way parity
        assign sum[i] = quadParity ^ chainIn[i];

        // top cell drops its carry and chain-out, sums wrap at rowWidth
        if (i < rowWidth - 1) begin : genUpper
            // all four set, or an odd count of them plus the chained bit
            assign carry[i+1] = (w[i] & x[i] & y[i] & z[i]) |
                                (chainIn[i] & quadParity);

            // two or more of w x y z
            // no dependence on chainIn, so the chain stops after one cell
            assign chainIn[i+1] = (w[i] | x[i] | y[i]) &
                                  (w[i] | x[i] | z[i]) &
                                  (w[i] | y[i] | z[i]) &
                                  (x[i] | y[i] | z[i]);
        end
    end

endmodule

//--- hw/compressorTree.sv
/*
 * compressorTree
 *   levels of reducer4to2 from all partial products down to two rows
 *   registered sum and carry rows with their control struct
 */
`timescale 1ns/10ps

module compressorTree #(
    parameter int opWidth = 32
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  mulPipePkg::mulCtlT   inCtl,
    input  logic [2*opWidth-1:0] rows [boothPkg::digitCount(opWidth)],
    output mulPipePkg::mulCtlT   outCtl,
    output logic [2*opWidth-1:0] sumRow,
    output logic [2*opWidth-1:0] carryRow
);
    import boothPkg::*;

    localparam int rowWidth  = 2 * opWidth;
    localparam int numRows   = digitCount(opWidth);
    // 4 levels for opWidth 32: 17, 9, 5, 3 rows in, 2 out
    localparam int numLevels = treeLevels(numRows);

    // lvlRows[l] holds the rows entering level l
    // slots past levelRows(numRows, l) are tied to zero
    logic [rowWidth-1:0] lvlRows [numLevels+1][numRows];

    for (genvar r = 0; r < numRows; r++) begin : genLoad
        assign lvlRows[0][r] = rows[r];
    end

    for (genvar lvl = 0; lvl < numLevels; lvl++) begin : genLevel
        localparam int inRows   = levelRows(numRows, lvl);
        localparam int outRows  = levelRows(numRows, lvl + 1);
        localparam int groups   = inRows / 4;
        localparam int leftover = inRows % 4;

        // full groups of four rows
        for (genvar g = 0; g < groups; g++) begin : genGroup
            reducer4to2 #(
                .rowWidth(rowWidth)
            ) reducer_i (
                .w    (lvlRows[lvl][4*g]),
                .x    (lvlRows[lvl][4*g+1]),
                .y    (lvlRows[lvl][4*g+2]),
                .z    (lvlRows[lvl][4*g+3]),
                .sum  (lvlRows[lvl+1][2*g]),
                .carry(lvlRows[lvl+1][2*g+1])
            );
        end

        if (leftover == 3) begin : genPad
            // three spare rows would never shrink, so reduce them with a zero row
            reducer4to2 #(
                .rowWidth(rowWidth)
            ) reducer_i (
                .w    (lvlRows[lvl][4*groups]),
                .x    (lvlRows[lvl][4*groups+1]),
                .y    (lvlRows[lvl][4*groups+2]),
                .z    ('0),
                .sum  (lvlRows[lvl+1][2*groups]),
                .carry(lvlRows[lvl+1][2*groups+1])
            );
        end else begin : genPass
            // one or two spare rows wait for the next level
            for (genvar p = 0; p < leftover; p++) begin : genRow
                assign lvlRows[lvl+1][2*groups+p] = lvlRows[lvl][4*groups+p];
            end
        end

        for (genvar u = outRows; u < numRows; u++) begin : genIdle
            assign lvlRows[lvl+1][u] = '0;
        end
    end

    // pipeline register between the tree and the final adder
    always_ff @(posedge clk) begin
        sumRow   <= lvlRows[numLevels][0];
        carryRow <= lvlRows[numLevels][1];
        outCtl   <= inCtl;
        if (!rstN) begin
            outCtl.valid <= 1'b0;
        end
    end

endmodule

//--- hw/boothMultiplier.sv
/*
 * boothMultiplier
 *   pipelined radix-4 Booth multiplier, signed or unsigned per request
 *   input register, encoder, row generator, 4-to-2 tree, ripple adder
 *   fixed latency of three stages, one request per clock
 */
`timescale 1ns/10ps

module boothMultiplier #(
    parameter int opWidth = 32
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  mulPipePkg::mulCtlT   inCtl,
    input  logic [opWidth-1:0]   multiplicand,
    input  logic [opWidth-1:0]   multiplier,
    output mulPipePkg::mulCtlT   outCtl,
    output logic [2*opWidth-1:0] product
);
    import boothPkg::*;
    import mulPipePkg::*;

    localparam int numDigits = digitCount(opWidth);
    localparam int prodWidth = 2 * opWidth;

    // stage 1 registers
    mulCtlT               ctlS1;
    logic [opWidth-1:0]   multiplicandS1;
    logic [opWidth-1:0]   multiplierS1;

    // stage 2 combinational paths and tree registers
    boothDigitT           digits [numDigits];
    logic [prodWidth-1:0] ppRows [numDigits];
    mulCtlT               ctlS2;
    logic [prodWidth-1:0] sumRow;
    logic [prodWidth-1:0] carryRow;

    // stage 3 adder output
    logic [prodWidth-1:0] rippleSum;

    // operands are captured every cycle, only valid is reset
    always_ff @(posedge clk) begin
        multiplicandS1 <= multiplicand;
        multiplierS1   <= multiplier;
        ctlS1          <= inCtl;
        if (!rstN) begin
            ctlS1.valid <= 1'b0;
        end
    end

    boothEncoder #(
        .opWidth(opWidth)
    ) encoder_i (
        .multiplier(multiplierS1),
        .signedMode(ctlS1.signedMode),
        .digits    (digits)
    );

    partialProductGen #(
        .opWidth(opWidth)
    ) ppGen_i (
        .multiplicand(multiplicandS1),
        .signedMode  (ctlS1.signedMode),
        .digits      (digits),
        .rows        (ppRows)
    );

    // reduces the rows and registers them, stage 2
    compressorTree #(
        .opWidth(opWidth)
    ) tree_i (
        .clk     (clk),
        .rstN    (rstN),
        .inCtl   (ctlS1),
        .rows    (ppRows),
        .outCtl  (ctlS2),
        .sumRow  (sumRow),
        .carryRow(carryRow)
    );

    // final carry-propagate add, plain ripple, carry out of the msb dropped
    always_comb begin
        logic rippleCarry;
        rippleCarry = 1'b0;
        for (int i = 0; i < prodWidth; i++) begin
            rippleSum[i] = sumRow[i] ^ carryRow[i] ^ rippleCarry;
            rippleCarry  = (sumRow[i] & carryRow[i]) |
                           (rippleCarry & (sumRow[i] ^ carryRow[i]));
        end
    end

    // stage 3 output register
    always_ff @(posedge clk) begin
        product <= rippleSum;
        outCtl  <= ctlS2;
        if (!rstN) begin
            outCtl.valid <= 1'b0;
        end
    end

endmodule

//--- sim/mulChecks.svh
/*
 * Result checking for the multiplier testbench
 *   checkCount, errorCount  running totals
 *   checkProduct, checkCtl  compare tasks on the DUT's own types
 *   reportFailure           failures that are not a wrong value
 */
`ifndef MUL_CHECKS_SVH
`define MUL_CHECKS_SVH

// every compare task adds one check
int checkCount = 0;
int errorCount = 0;

task automatic checkProduct(input logic [2*opWidth-1:0] actual,
                            input logic [2*opWidth-1:0] wanted,
                            input logic [tagWidth-1:0]  tag);
    checkCount++;
    if (actual !== wanted) begin
        errorCount++;
        $display("Error: product got 0x%h expected 0x%h (tag 0x%h)", actual, wanted, tag);
    end
endtask

// field by field, so the line names the field that is off
// valid timing is judged by the monitor against the due cycle
task automatic checkCtl(input mulCtlT actual, input mulCtlT wanted);
    checkCount++;
    if (actual.signedMode !== wanted.signedMode) begin
        errorCount++;
        $display("Error: outCtl.signedMode got 0x%h expected 0x%h",
                 actual.signedMode, wanted.signedMode);
    end
    if (actual.tag !== wanted.tag) begin
        errorCount++;
        $display("Error: outCtl.tag got 0x%h expected 0x%h", actual.tag, wanted.tag);
    end
endtask

// missing, late or extra results
task automatic reportFailure(input string msg);
    errorCount++;
    $display("%s", msg);
endtask

`endif

//--- sim/mulTb.sv
/*
 * Testbench for boothMultiplier
 *   clock, reset, LCG stimulus and a queue of expected results
 *   random signed and unsigned, corner operands, back-to-back order,
 *   valid gaps with a reset in mid-run, and a watchdog
 */
`timescale 1ns/10ps

module mulTb;
    import mulPipePkg::*;

    localparam int opWidth       = 32;
    localparam int prodWidth     = 2 * opWidth;
    localparam int clkPeriod     = 20;
    localparam int resetCycles   = 16;
    localparam int signedCount   = 300;
    localparam int unsignedCount = 300;
    // five corner values, every pairing, both modes
    localparam int cornerCount   = 2 * 5 * 5;
    localparam int orderCount    = 64;
    localparam int gapCycles     = 200;
    // idle cycles allowed for the last results of a test
    localparam int drainLimit    = 8;
    // two resets with quiet cycles, all tests, their drains, plus margin
    localparam int totalCycles   = 2 * (resetCycles + 4) + signedCount + unsignedCount +
                                   cornerCount + orderCount + gapCycles +
                                   6 * drainLimit + 100;

    // one request in flight and the cycle its result is due
    typedef struct packed {
        mulCtlT               ctl;
        logic [prodWidth-1:0] prod;
        logic [31:0]          dueCycle;
    } expectT;

    `include "mulChecks.svh"

    logic                 clk = 1'b0;
    logic                 rstN = 1'b0;
    mulCtlT               inCtl = '0;
    logic [opWidth-1:0]   multiplicand = '0;
    logic [opWidth-1:0]   multiplier = '0;
    mulCtlT               outCtl;
    logic [prodWidth-1:0] product;

    logic [31:0]          lcgState = 32'd45;
    // updated by NBA, so every process at an edge sees the same count
    logic [31:0]          cycle = '0;
    logic [tagWidth-1:0]  nextTag = '0;
    int                   sentCount = 0;
    int                   testErrors0;
    int                   testSent0;
    expectT               pending [$];

    boothMultiplier #(
        .opWidth(opWidth)
    ) dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .inCtl       (inCtl),
        .multiplicand(multiplicand),
        .multiplier  (multiplier),
        .outCtl      (outCtl),
        .product     (product)
    );

    initial begin
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // 32-bit LCG, the upper bits are the usable ones
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [opWidth-1:0] randOperand();
        logic [opWidth-1:0] v;
        logic [31:0]        r;
        for (int i = 0; i < opWidth; i += 8) begin
            r = nextRand();
            v[i +: 8] = r[31:24];
        end
        return v;
    endfunction

    // full-width product of the extended operands, kept modulo 2^prodWidth
    function automatic logic [prodWidth-1:0] modelProduct(input logic [opWidth-1:0] a,
                                                          input logic [opWidth-1:0] b,
                                                          input logic sm);
        logic [prodWidth-1:0] extA;
        logic [prodWidth-1:0] extB;
        extA = {{opWidth{sm & a[opWidth-1]}}, a};
        extB = {{opWidth{sm & b[opWidth-1]}}, b};
        return extA * extB;
    endfunction

    task automatic sendRequest(input logic sm, input logic [opWidth-1:0] a,
                               input logic [opWidth-1:0] b);
        expectT ent;
        @(posedge clk);
        inCtl        <= '{valid: 1'b1, signedMode: sm, tag: nextTag};
        multiplicand <= a;
        multiplier   <= b;
        ent.ctl  = '{valid: 1'b1, signedMode: sm, tag: nextTag};
        ent.prod = modelProduct(a, b, sm);
        // sampled at the next edge, visible to the monitor three edges later
        ent.dueCycle = cycle + 32'd4;
        pending.push_back(ent);
        nextTag = nextTag + 1'b1;
        sentCount++;
    endtask

    // valid low with junk on the operands
    task automatic idleCycle();
        @(posedge clk);
        inCtl.valid  <= 1'b0;
        multiplicand <= randOperand();
        multiplier   <= randOperand();
    endtask

    task automatic applyReset(input int cycles, input logic junkValid);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            rstN         <= 1'b0;
            inCtl        <= '{valid: junkValid, signedMode: 1'b1, tag: '1};
            multiplicand <= randOperand();
            multiplier   <= randOperand();
        end
        @(posedge clk);
        rstN        <= 1'b1;
        inCtl.valid <= 1'b0;
        // no result may show up in these cycles
        for (int i = 0; i < 3; i++) begin
            idleCycle();
        end
    endtask

    task automatic drainPipe();
        int waited;
        waited = 0;
        while (pending.size() != 0 && waited < drainLimit) begin
            idleCycle();
            waited++;
        end
        if (pending.size() != 0) begin
            reportFailure($sformatf("%0d results never arrived", pending.size()));
            pending.delete();
        end
    endtask

    task automatic runRandom(input logic sm, input int count);
        logic [opWidth-1:0] a;
        logic [opWidth-1:0] b;
        for (int i = 0; i < count; i++) begin
            a = randOperand();
            b = randOperand();
            // unsigned runs force the msb on part of the operands
            if (!sm && i % 4 == 0) begin
                a[opWidth-1] = 1'b1;
            end
            if (!sm && i % 3 == 0) begin
                b[opWidth-1] = 1'b1;
            end
            sendRequest(sm, a, b);
        end
    endtask

    task automatic runCorners();
        logic [opWidth-1:0] corners [5];
        // -1 and all ones share a pattern, so the largest positive fills the slot
        corners[0] = {1'b1, {(opWidth-1){1'b0}}};
        corners[1] = '1;
        corners[2] = '0;
        corners[3] = {{(opWidth-1){1'b0}}, 1'b1};
        corners[4] = {1'b0, {(opWidth-1){1'b1}}};
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    sendRequest(m[0], corners[i], corners[j]);
                end
            end
        end
    endtask

    // back to back, mode toggling, tags counting up
    task automatic runOrder();
        for (int i = 0; i < orderCount; i++) begin
            sendRequest(i[0], randOperand(), randOperand());
        end
    endtask

    task automatic runGaps();
        logic [31:0] r;
        for (int i = 0; i < gapCycles; i++) begin
            r = nextRand();
            if (r[31]) begin
                sendRequest(r[30], randOperand(), randOperand());
            end else begin
                idleCycle();
            end
        end
        drainPipe();
        // junk requests during this reset must never come out
        applyReset(resetCycles, 1'b1);
    endtask

    task automatic beginTest();
        testErrors0 = errorCount;
        testSent0   = sentCount;
    endtask

    task automatic endTest(input string name);
        $display("test %s: requests %0d, errors %0d",
                 name, sentCount - testSent0, errorCount - testErrors0);
    endtask

    // results in order, each exactly at its due cycle
    always @(posedge clk) begin
        expectT ent;
        if (outCtl.valid) begin
            if (pending.size() == 0) begin
                if (!rstN) begin
                    reportFailure($sformatf("outCtl.valid high during reset at cycle %0d",
                                            cycle));
                end else begin
                    reportFailure($sformatf("extra result with tag 0x%h at cycle %0d",
                                            outCtl.tag, cycle));
                end
            end else begin
                ent = pending.pop_front();
                if (ent.dueCycle != cycle) begin
                    reportFailure($sformatf("result for tag 0x%h came at cycle %0d, due %0d",
                                            ent.ctl.tag, cycle, ent.dueCycle));
                end
                checkCtl(outCtl, ent.ctl);
                checkProduct(product, ent.prod, ent.ctl.tag);
            end
        end else if (pending.size() != 0 && pending[0].dueCycle <= cycle) begin
            ent = pending.pop_front();
            reportFailure($sformatf("result for tag 0x%h missing at cycle %0d",
                                    ent.ctl.tag, cycle));
        end
    end

    initial begin
        #(totalCycles * clkPeriod);
        $display("watchdog expired after %0d cycles", totalCycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        beginTest();
        applyReset(resetCycles, 1'b0);
        endTest("reset");
        beginTest();
        runRandom(1'b1, signedCount);
        drainPipe();
        endTest("random signed");
        beginTest();
        runRandom(1'b0, unsignedCount);
        drainPipe();
        endTest("random unsigned");
        beginTest();
        runCorners();
        drainPipe();
        endTest("corner operands");
        beginTest();
        runOrder();
        drainPipe();
        endTest("throughput and order");
        beginTest();
        runGaps();
        endTest("gaps and reset");
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+sim
hw/boothPkg.sv
hw/mulPipePkg.sv
hw/boothEncoder.sv
hw/partialProductGen.sv
hw/reducer4to2.sv
hw/compressorTree.sv
hw/boothMultiplier.sv
sim/mulTb.sv

//--- runSim.sh
#!/bin/sh
# builds the multiplier testbench with Verilator and runs it
# the verdict comes from the pass line in the simulation log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f compile.f \
    --top-module mulTb \
    -o mulTbSim

./obj_dir/mulTbSim > sim.log
cat sim.log

if grep -qx "Simulation completed successfully" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
